// ==== Makefile ====
# Verilator build and run of the FP32 unit testbench

VERILATOR ?= verilator
TOP       ?= fpu_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failures found
VFLAGS    ?= --binary --timing --assert -j 0

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, search $(LOG) for failures"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG FAIL_MSG VFLAGS"

$(SIM): $(FILELIST) $(SRCS) fpu_consts.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# a crash without the fail message still counts as a failure
test: $(SIM)
	@status=0; ./$(SIM) > $(LOG) 2>&1 || status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation finished clean"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== fpu_add.sv ====
`default_nettype none

`include "fpu_consts.svh"

module fpu_add (
    input  logic           clk,
    input  logic           reset,
    input  fpu_pkg::fp32_t a,
    input  fpu_pkg::fp32_t b,
    input  logic           sub,
    output fpu_pkg::fp32_t result
);
    import fpu_pkg::*;

    // position of the leading one counted from bit 23, 0 when bit 23 is set
    function automatic logic [4:0] lead_zeros(input man_t v);
        logic [4:0] n;
        n = 5'd0;
        for (int i = 0; i <= `FPU_FRAC_W; i++) begin
            if (v[i]) begin
                n = 5'(`FPU_FRAC_W - i);  // highest set bit wins, loop runs upward
            end
        end
        return n;
    endfunction

    logic                 sign_a;    // operand signs, b after the sub flip
    logic                 sign_b;
    logic                 a_big;     // a has the larger or equal magnitude
    logic                 sign_big;  // sign of the larger operand, result sign
    logic                 eff_sub;   // signs differ, magnitudes subtract
    exp_t                 exp_big;   // exponent of larger operand
    exp_t                 exp_small;
    frac_t                frac_big;
    frac_t                frac_small;
    exp_t                 exp_diff;  // alignment distance, never negative
    man_t                 man_big;
    man_t                 man_small; // zero if the small operand is flushed
    man_t                 man_al;    // small mantissa after alignment
    logic [`FPU_FRAC_W+1:0] sum;     // 25 bits, top bit is carry out
    logic [4:0]           lz;        // normalize left shift
    man_t                 man_n;     // normalized mantissa
    exp_wide_t            exp_res;   // exponent after normalize
    logic                 both_zero; // both exponent fields zero
    logic                 ovf;       // exponent out of range high
    logic                 uflow;     // exponent out of range low
    fp32_t                res_d;     // next result word

    assign sign_a = a[`FPU_WORD_W-1];
    assign sign_b = b[`FPU_WORD_W-1] ^ sub;  // subtraction is add with b negated

    // magnitude order, exponent then fraction, is just the low 31 bits as unsigned
    assign a_big = (a[`FPU_WORD_W-2:0] >= b[`FPU_WORD_W-2:0]);

    always_comb begin
        // operand swap
        if (a_big) begin
            sign_big   = sign_a;
            exp_big    = a[`FPU_WORD_W-2 -: `FPU_EXP_W];
            frac_big   = a[`FPU_FRAC_W-1:0];
            exp_small  = b[`FPU_WORD_W-2 -: `FPU_EXP_W];
            frac_small = b[`FPU_FRAC_W-1:0];
        end else begin
            sign_big   = sign_b;
            exp_big    = b[`FPU_WORD_W-2 -: `FPU_EXP_W];
            frac_big   = b[`FPU_FRAC_W-1:0];
            exp_small  = a[`FPU_WORD_W-2 -: `FPU_EXP_W];
            frac_small = a[`FPU_FRAC_W-1:0];
        end
        eff_sub   = sign_a ^ sign_b;
        both_zero = (exp_big == '0);  // big has the larger exponent, so small is zero too

        man_big   = {1'b1, frac_big};
        man_small = (exp_small == '0) ? '0 : {1'b1, frac_small};  // flushed operand

        // alignment, shifted out bits are lost
        exp_diff = exp_big - exp_small;
        if (exp_diff >= exp_t'(`FPU_FRAC_W + 2)) begin
            man_al = '0;  // 25 or more places, nothing left
        end else begin
            man_al = man_small >> exp_diff;
        end

        // signed magnitude combine, big >= small so no borrow out
        if (eff_sub) begin
            sum = {1'b0, man_big} - {1'b0, man_al};
        end else begin
            sum = {1'b0, man_big} + {1'b0, man_al};
        end

        // normalize
        if (sum[`FPU_FRAC_W+1]) begin  // carry out, shift right once
            lz      = 5'd0;
            man_n   = sum[`FPU_FRAC_W+1:1];  // low bit dropped
            exp_res = exp_wide_t'({2'b00, exp_big}) + exp_wide_t'(1);
        end else begin
            lz      = lead_zeros(sum[`FPU_FRAC_W:0]);
            man_n   = sum[`FPU_FRAC_W:0] << lz;
            exp_res = exp_wide_t'({2'b00, exp_big}) - exp_wide_t'({5'b0, lz});
        end

        ovf   = (exp_res >= exp_wide_t'(`FPU_EXP_MAX));
        uflow = (exp_res <= exp_wide_t'(0));

        // special results first, then the normal pack
        if (both_zero || (sum == '0)) begin
            res_d = '0;  // exact zero is always +0
        end else if (ovf) begin
            res_d = {sign_big, exp_t'(`FPU_EXP_MAX), frac_t'(0)};
        end else if (uflow) begin
            res_d = {sign_big, {(`FPU_WORD_W-1){1'b0}}};  // flush keeps the sign
        end else begin
            res_d = {sign_big, exp_res[`FPU_EXP_W-1:0], man_n[`FPU_FRAC_W-1:0]};
        end
    end

    // result register, loads every cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '0;
        end else begin
            result <= res_d;
        end
    end

    // exponent 255 only ever with a zero fraction
    a_add_no_nan: assert property (
        @(posedge clk) disable iff (reset)
        !((result[`FPU_WORD_W-2 -: `FPU_EXP_W] == exp_t'(`FPU_EXP_MAX))
          && (result[`FPU_FRAC_W-1:0] != '0))
    ) else $error("fpu_add: NaN pattern on result");

    // a registered zero magnitude is +0 unless the exponent underflowed
    a_add_pos_zero: assert property (
        @(posedge clk) disable iff (reset)
        ((result[`FPU_WORD_W-2:0] == '0) && !$past(uflow)) |-> !result[`FPU_WORD_W-1]
    ) else $error("fpu_add: zero result with negative sign");

endmodule

`default_nettype wire

// ==== fpu_consts.svh ====
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// binary32 field layout
`define FPU_WORD_W 32  // whole word
`define FPU_EXP_W 8    // biased exponent field
`define FPU_FRAC_W 23  // stored fraction, hidden one not included

// exponent encoding
`define FPU_BIAS 127     // exponent bias
`define FPU_EXP_MAX 255  // all ones, infinity

// operation codes, bit 1 picks the multiplier
`define FPU_OP_ADD 2'd0  // a + b
`define FPU_OP_SUB 2'd1  // a - b
`define FPU_OP_MUL 2'd2  // a * b, code 3 lands here too

`endif

// ==== fpu_mul.sv ====
`default_nettype none

`include "fpu_consts.svh"

module fpu_mul (
    input  logic           clk,
    input  logic           reset,
    input  fpu_pkg::fp32_t a,
    input  fpu_pkg::fp32_t b,
    output fpu_pkg::fp32_t result
);
    import fpu_pkg::*;

    logic      sign_r;     // result sign
    exp_t      exp_a;      // operand exponent fields
    exp_t      exp_b;
    man_t      man_a;      // mantissas with hidden one
    man_t      man_b;
    logic      zero_op;    // either operand flushed to zero
    prod_t     prod;       // 48 bit mantissa product
    exp_wide_t exp_sum;    // exponent before normalize
    exp_wide_t exp_norm;   // exponent after normalize
    frac_t     frac_n;     // truncated fraction
    fp32_t     res_d;      // next result word

    // field unpack
    assign sign_r = a[`FPU_WORD_W-1] ^ b[`FPU_WORD_W-1];  // sign is always the xor
    assign exp_a  = a[`FPU_WORD_W-2 -: `FPU_EXP_W];
    assign exp_b  = b[`FPU_WORD_W-2 -: `FPU_EXP_W];
    assign man_a  = {1'b1, a[`FPU_FRAC_W-1:0]};      // hidden one restored
    assign man_b  = {1'b1, b[`FPU_FRAC_W-1:0]};

    // zero exponent field means zero or subnormal, both flushed
    assign zero_op = (exp_a == '0) || (exp_b == '0);

    assign prod = man_a * man_b;  // 1.x * 1.y lands in [1, 4)

    // biased sum, widened and signed so the range check sees the true value
    assign exp_sum = exp_wide_t'({2'b00, exp_a}) + exp_wide_t'({2'b00, exp_b})
                   - exp_wide_t'(`FPU_BIAS);

    always_comb begin
        // normalize by at most one place, truncate the rest
        if (prod[2*`FPU_FRAC_W+1]) begin  // product >= 2.0
            exp_norm = exp_sum + exp_wide_t'(1);
            frac_n   = prod[2*`FPU_FRAC_W -: `FPU_FRAC_W];    // bits 46..24
        end else begin
            exp_norm = exp_sum;
            frac_n   = prod[2*`FPU_FRAC_W-1 -: `FPU_FRAC_W];  // bits 45..23
        end

        // range mapping
        if (zero_op) begin
            res_d = {sign_r, {(`FPU_WORD_W-1){1'b0}}};  // signed zero
        end else if (exp_norm >= exp_wide_t'(`FPU_EXP_MAX)) begin
            res_d = {sign_r, exp_t'(`FPU_EXP_MAX), frac_t'(0)};  // signed infinity
        end else if (exp_norm <= exp_wide_t'(0)) begin
            res_d = {sign_r, {(`FPU_WORD_W-1){1'b0}}};  // underflow, flush to zero
        end else begin
            res_d = {sign_r, exp_norm[`FPU_EXP_W-1:0], frac_n};
        end
    end

    // result register, loads every cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '0;
        end else begin
            result <= res_d;
        end
    end

    // a zero operand must show up as zero magnitude on the next cycle
    a_mul_zero_op: assert property (
        @(posedge clk) disable iff (reset)
        zero_op |=> (result[`FPU_WORD_W-2:0] == '0)
    ) else $error("fpu_mul: zero operand gave nonzero magnitude");

    // infinity is the only all-ones exponent the unit may emit
    a_mul_no_nan: assert property (
        @(posedge clk) disable iff (reset)
        !((result[`FPU_WORD_W-2 -: `FPU_EXP_W] == exp_t'(`FPU_EXP_MAX))
          && (result[`FPU_FRAC_W-1:0] != '0))
    ) else $error("fpu_mul: NaN pattern on result");

endmodule

`default_nettype wire

// ==== fpu_pkg.sv ====
`default_nettype none

`include "fpu_consts.svh"

package fpu_pkg;

    // full binary32 word, sign / exponent / fraction
    typedef logic [`FPU_WORD_W-1:0] fp32_t;

    // biased exponent as stored in the word
    typedef logic [`FPU_EXP_W-1:0] exp_t;

    // stored fraction without the hidden bit
    typedef logic [`FPU_FRAC_W-1:0] frac_t;

    // mantissa with the hidden one in the top bit
    typedef logic [`FPU_FRAC_W:0] man_t;

    // intermediate exponent, two extra bits so overflow and
    // underflow stay visible before the range check
    typedef logic signed [`FPU_EXP_W+1:0] exp_wide_t;

    // full mantissa product, 24 x 24 bits
    typedef logic [2*(`FPU_FRAC_W+1)-1:0] prod_t;

    // operation code at the top level
    typedef logic [1:0] fpu_op_t;

endpackage

`default_nettype wire

// ==== fpu_tb.sv ====
`default_nettype none

`include "fpu_consts.svh"

module fpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fpu_pkg::*;

    localparam int CLK_HALF     = 2;       // 4 ns clock
    localparam int RESET_CYCLES = 5;
    localparam int N_DIRECTED   = 40;      // directed ops plus their idle and drain cycles
    localparam int N_STREAM     = 300;     // back to back random ops
    localparam int N_GAP_OPS    = 100;     // random ops with idle gaps
    localparam int MAX_GAP      = 3;       // longest idle gap in cycles
    localparam int ISSUE_CYCLES = RESET_CYCLES + N_DIRECTED + N_STREAM
                                + N_GAP_OPS * (MAX_GAP + 1);
    localparam int CYCLE_LIMIT  = 4 * ISSUE_CYCLES + 100;
    localparam logic [31:0] SEED = 32'h86e8_4d8a;

    logic    clk;
    logic    reset;
    logic    in_valid;
    fpu_op_t op;
    fp32_t   a;
    fp32_t   b;
    logic    out_valid;
    fp32_t   result;

    fp32_t exp_q[$];   // expected words, oldest first
    string msg_q[$];   // operation text for error lines
    int    cyc_q[$];   // cycle in which each op was issued

    logic [31:0] lcg_state;
    int cycle_cnt  = 0;  // rising edges since time 0
    int pass_cnt   = 0;  // word and valid checks
    int fail_cnt   = 0;
    int count_pass = 0;  // count checks from the stimulus side
    int count_fail = 0;
    int valid_seen = 0;  // out_valid pulses observed
    int issued_cnt = 0;  // operations sent

    fpu_top uut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // expected result straight from the arithmetic rules
    function automatic fp32_t fpu_model(input fpu_op_t o, input fp32_t x, input fp32_t y);
        logic        sign_x;
        logic        sign_y;
        logic        sign_r;
        logic        sign_big;
        int          exp_x;
        int          exp_y;
        int          exp_big;
        int          exp_small;
        int          exp_r;
        logic [22:0] frac_big;
        logic [22:0] frac_small;
        logic [22:0] frac;
        logic [23:0] man_x;
        logic [23:0] man_y;
        logic [23:0] man_big;
        logic [23:0] man_small;
        logic [47:0] prod;
        logic [24:0] mag;    // magnitude with carry bit
        sign_x = x[31];
        sign_y = y[31];
        exp_x  = int'(x[30:23]);
        exp_y  = int'(y[30:23]);
        man_x  = {1'b1, x[22:0]};
        man_y  = {1'b1, y[22:0]};
        if (o[1]) begin                               // codes 2 and 3 multiply
            sign_r = sign_x ^ sign_y;
            if (exp_x == 0 || exp_y == 0) begin
                return {sign_r, 31'd0};
            end
            prod  = 48'(man_x) * 48'(man_y);
            exp_r = exp_x + exp_y - `FPU_BIAS;
            if (prod[47]) begin
                exp_r = exp_r + 1;
                frac  = prod[46:24];
            end else begin
                frac  = prod[45:23];
            end
            if (exp_r >= `FPU_EXP_MAX) begin
                return {sign_r, exp_t'(`FPU_EXP_MAX), 23'd0};
            end
            if (exp_r <= 0) begin
                return {sign_r, 31'd0};
            end
            return {sign_r, exp_r[7:0], frac};
        end
        if (o == `FPU_OP_SUB) begin
            sign_y = ~sign_y;                         // a - b is a + (-b)
        end
        if (exp_x > exp_y || (exp_x == exp_y && x[22:0] >= y[22:0])) begin
            sign_big   = sign_x;
            exp_big    = exp_x;
            frac_big   = x[22:0];
            exp_small  = exp_y;
            frac_small = y[22:0];
        end else begin
            sign_big   = sign_y;
            exp_big    = exp_y;
            frac_big   = y[22:0];
            exp_small  = exp_x;
            frac_small = x[22:0];
        end
        if (exp_big == 0) begin
            return 32'd0;                             // both operands zero
        end
        man_big   = {1'b1, frac_big};
        man_small = (exp_small == 0) ? 24'd0 : {1'b1, frac_small};
        if (exp_big - exp_small >= 25) begin
            man_small = 24'd0;
        end else begin
            man_small = man_small >> (exp_big - exp_small);
        end
        if (sign_x == sign_y) begin
            mag = {1'b0, man_big} + {1'b0, man_small};
        end else begin
            mag = {1'b0, man_big} - {1'b0, man_small};
        end
        exp_r = exp_big;
        if (mag == 25'd0) begin
            return 32'd0;
        end
        if (mag[24]) begin
            mag   = mag >> 1;                         // carry out, low bit lost
            exp_r = exp_r + 1;
        end else begin
            while (!mag[23]) begin
                mag   = mag << 1;
                exp_r = exp_r - 1;
            end
        end
        if (exp_r >= `FPU_EXP_MAX) begin
            return {sign_big, exp_t'(`FPU_EXP_MAX), 23'd0};
        end
        if (exp_r <= 0) begin
            return {sign_big, 31'd0};
        end
        return {sign_big, exp_r[7:0], mag[22:0]};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int total_fails();
        return fail_cnt + count_fail;
    endfunction

    task automatic check_word(input fp32_t got, input fp32_t exp, input string msg);
        if (got === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("[FAIL] %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string msg);
        if (got === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("[FAIL] %0t: %s, out_valid %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string msg);
        if (got == exp) begin
            count_pass++;
        end else begin
            count_fail++;
            $display("[FAIL] %0t: %s, got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    // random word, mostly with exponents near 1.0 so adds overlap
    task automatic rand_operand(output fp32_t w);
        logic [31:0] pick;
        lcg_state = lcg_next(lcg_state);
        pick      = lcg_state;
        lcg_state = lcg_next(lcg_state);
        w         = lcg_state;
        if (pick[31:30] != 2'd0) begin
            w[30:23] = 8'd120 + {4'd0, pick[27:24]};
        end
        if (w[30:23] == 8'hff) begin
            w[30:23] = 8'hfe;                         // keep infinity and NaN out
        end
    endtask

    task automatic rand_op(output fpu_op_t o);
        lcg_state = lcg_next(lcg_state);
        o         = lcg_state[31:30];                 // all four codes
    endtask

    task automatic rand_gap(output int g);
        lcg_state = lcg_next(lcg_state);
        g         = int'(lcg_state[31:24]) % (MAX_GAP + 1);
    endtask

    // called at 1 ns past a rising edge, returns at the same phase
    task automatic issue(input fpu_op_t o, input fp32_t x, input fp32_t y);
        in_valid = 1'b1;
        op       = o;
        a        = x;
        b        = y;
        exp_q.push_back(fpu_model(o, x, y));
        msg_q.push_back($sformatf("op %0d a %h b %h", o, x, y));
        cyc_q.push_back(cycle_cnt);
        issued_cnt++;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain();
        while (cyc_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (total_fails() == fails_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, total_fails() - fails_before);
        end
    endtask

    // result due one cycle after the issue, nothing in between
    always @(negedge clk) begin : compare
        logic  due;
        int    cyc_tmp;
        fp32_t exp_tmp;
        string msg_tmp;
        due = (cyc_q.size() != 0) && (cyc_q[0] == cycle_cnt - 1);
        if (reset) begin
            check_valid(out_valid, 1'b0, "out_valid during reset");
        end else begin
            check_valid(out_valid, due, "out_valid one cycle after issue only");
            if (out_valid) begin
                valid_seen++;
            end
            if (due) begin
                cyc_tmp = cyc_q.pop_front();
                exp_tmp = exp_q.pop_front();
                msg_tmp = msg_q.pop_front();
                if (out_valid) begin
                    check_word(result, exp_tmp, msg_tmp);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin : main
        fp32_t   x;
        fp32_t   y;
        fpu_op_t o;
        int      gap;
        int      fails_before;
        int      seen_before;
        int      issued_before;
        reset     = 1'b1;
        in_valid  = 1'b0;
        op        = '0;
        a         = '0;
        b         = '0;
        lcg_state = SEED;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        fails_before = total_fails();
        seen_before  = valid_seen;
        idle(2);
        issue(`FPU_OP_ADD, 32'h3f80_0000, 32'h4000_0000);
        idle(3);
        drain();
        check_count(valid_seen - seen_before, 1, "pulses for one isolated operation");
        report_test("reset and latency", fails_before);

        fails_before = total_fails();
        issue(`FPU_OP_MUL, 32'h3fc0_0000, 32'h4000_0000);  // 1.5 * 2.0
        issue(`FPU_OP_MUL, 32'hc040_0000, 32'h4020_0000);  // -3.0 * 2.5
        issue(`FPU_OP_MUL, 32'h0000_0000, 32'h40a0_0000);  // zero operand
        issue(2'd3, 32'h8000_0000, 32'h3f80_0000);         // code 3, -0 * 1
        issue(`FPU_OP_MUL, 32'h7f00_0000, 32'h7f00_0000);  // overflow
        issue(`FPU_OP_MUL, 32'h0100_0000, 32'h8100_0000);  // underflow, negative
        issue(`FPU_OP_MUL, 32'h3f80_0001, 32'h3f80_0001);  // truncated low bits
        drain();
        report_test("directed multiplies", fails_before);

        fails_before = total_fails();
        issue(`FPU_OP_ADD, 32'h4049_0fdb, 32'hc049_0fdb);  // cancels to +0
        issue(`FPU_OP_SUB, 32'h3f80_0000, 32'h3f80_0000);  // cancels to +0
        issue(`FPU_OP_ADD, 32'h3fc0_0000, 32'h3fc0_0000);  // carry out
        issue(`FPU_OP_ADD, 32'h7f7f_ffff, 32'h7f7f_ffff);  // carry into infinity
        issue(`FPU_OP_SUB, 32'h3f80_0001, 32'h3f80_0000);  // 23 place normalize
        issue(`FPU_OP_SUB, 32'h4000_0000, 32'h3ff0_0000);  // few place normalize
        issue(`FPU_OP_ADD, 32'h4c00_0000, 32'h3f80_0000);  // shift of 25
        issue(`FPU_OP_SUB, 32'h3f80_0000, 32'hb300_0000);  // shift of 25, b negative
        issue(`FPU_OP_SUB, 32'h3f80_0000, 32'h4040_0000);  // b bigger, sign flips
        drain();
        report_test("directed adds and subtracts", fails_before);

        fails_before = total_fails();
        repeat (N_STREAM) begin
            rand_op(o);
            rand_operand(x);
            rand_operand(y);
            issue(o, x, y);
        end
        drain();
        report_test("back to back stream", fails_before);

        fails_before  = total_fails();
        seen_before   = valid_seen;
        issued_before = issued_cnt;
        repeat (N_GAP_OPS) begin
            rand_op(o);
            rand_operand(x);
            rand_operand(y);
            issue(o, x, y);
            rand_gap(gap);
            idle(gap);
        end
        drain();
        check_count(valid_seen - seen_before, issued_cnt - issued_before,
                    "out_valid pulses against issued operations");
        report_test("gaps in the valid strobe", fails_before);

        $display("checks passed %0d, failed %0d", pass_cnt + count_pass, total_fails());
        if (total_fails() == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fpu_top.sv ====
`default_nettype none

module fpu_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  fpu_pkg::fpu_op_t op,
    input  fpu_pkg::fp32_t   a,
    input  fpu_pkg::fp32_t   b,
    output logic             out_valid,
    output fpu_pkg::fp32_t   result
);
    import fpu_pkg::*;

    fpu_op_t op_q;     // op code aligned with the unit result registers
    logic    valid_q;  // in_valid delayed by one
    fp32_t   mul_res;  // registered unit results
    fp32_t   add_res;

    // both units see every operand pair, only the select differs
    fpu_mul u_mul (
        .clk    (clk),
        .reset  (reset),
        .a      (a),
        .b      (b),
        .result (mul_res)
    );

    fpu_add u_add (
        .clk    (clk),
        .reset  (reset),
        .a      (a),
        .b      (b),
        .sub    (op[0]),  // code 1 is subtract
        .result (add_res)
    );

    // tag pipeline, one stage to match the units
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op_q    <= '0;
            valid_q <= 1'b0;
        end else begin
            op_q    <= op;
            valid_q <= in_valid;
        end
    end

    assign result    = op_q[1] ? mul_res : add_res;  // codes 2 and 3 multiply
    assign out_valid = valid_q;

    // nothing may come out on the first edge after reset is released
    a_top_quiet_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> !out_valid
    ) else $error("fpu_top: out_valid high right after reset");

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
fpu_pkg.sv
fpu_mul.sv
fpu_add.sv
fpu_top.sv
fpu_tb.sv
